// File: Makefile
TOP = jacobian_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// File: all.f
source/kin_pkg.sv
source/fixed_mult.sv
source/frame_capture.sv
source/cross_product.sv
source/jacobian_engine.sv
source/column_emitter.sv
source/jacobian_top.sv
test/jacobian_tb.sv

// File: source/column_emitter.sv
module column_emitter (
	input  logic                i,
	input  logic                reset,
	input  logic                result_valid,
	input  kin_pkg::coord_t     lin_0,
	input  kin_pkg::coord_t     lin_1,
	input  kin_pkg::coord_t     lin_2,
	input  kin_pkg::coord_t     ang_0,
	input  kin_pkg::coord_t     ang_1,
	input  kin_pkg::coord_t     ang_2,
	output logic                col_valid,
	output kin_pkg::joint_idx_t col_index,
	output kin_pkg::coord_t     jv_0,
	output kin_pkg::coord_t     jv_1,
	output kin_pkg::coord_t     jv_2,
	output kin_pkg::coord_t     jw_0,
	output kin_pkg::coord_t     jw_1,
	output kin_pkg::coord_t     jw_2,
	output logic                set_done
);
	import kin_pkg::*;

	localparam joint_idx_t LAST_COL = joint_idx_t'(NUM_JOINTS - 1);

	joint_idx_t col_count;

	// Column index counts results and wraps after the last joint
	always_ff @(posedge i) begin
		if (reset) begin
			col_valid <= 1'b0;
			set_done  <= 1'b0;
			col_index <= '0;
			col_count <= '0;
		end else begin
			col_valid <= result_valid;
			set_done  <= result_valid && (col_count == LAST_COL);
			if (result_valid) begin
				col_index <= col_count;
				col_count <= (col_count == LAST_COL) ? '0 : col_count + joint_idx_t'(1);
			end
		end
	end

	always_ff @(posedge i) begin
		if (result_valid) begin
			jv_0 <= lin_0;
			jv_1 <= lin_1;
			jv_2 <= lin_2;
			jw_0 <= ang_0;
			jw_1 <= ang_1;
			jw_2 <= ang_2;
		end
	end

	index_in_range: assert property (@(posedge i) disable iff (reset)
		col_valid |-> col_index <= LAST_COL)
		else $error("column index %0d past the last joint", col_index);

endmodule

// File: source/cross_product.sv
module cross_product #(
	parameter int FRAC_BITS = 20
) (
	input  logic            i,
	input  logic            reset,
	input  kin_pkg::coord_t a_0,
	input  kin_pkg::coord_t a_1,
	input  kin_pkg::coord_t a_2,
	input  kin_pkg::coord_t b_0,
	input  kin_pkg::coord_t b_1,
	input  kin_pkg::coord_t b_2,
	output kin_pkg::coord_t c_0,
	output kin_pkg::coord_t c_1,
	output kin_pkg::coord_t c_2
);
	import kin_pkg::*;

	coord_t a_vec [3];
	coord_t b_vec [3];
	coord_t prod_lhs [3];
	coord_t prod_rhs [3];
	coord_t c_vec [3];

	assign a_vec[0] = a_0;
	assign a_vec[1] = a_1;
	assign a_vec[2] = a_2;
	assign b_vec[0] = b_0;
	assign b_vec[1] = b_1;
	assign b_vec[2] = b_2;

	// Component k is a[k+1]*b[k+2] - a[k+2]*b[k+1], indices mod 3
	for (genvar k = 0; k < 3; k++) begin : g_comp
		fixed_mult #(
			.FRAC_BITS(FRAC_BITS)
		) mult_lhs_inst (
			.i     (i),
			.reset (reset),
			.a     (a_vec[(k + 1) % 3]),
			.b     (b_vec[(k + 2) % 3]),
			.p     (prod_lhs[k])
		);

		fixed_mult #(
			.FRAC_BITS(FRAC_BITS)
		) mult_rhs_inst (
			.i     (i),
			.reset (reset),
			.a     (a_vec[(k + 2) % 3]),
			.b     (b_vec[(k + 1) % 3]),
			.p     (prod_rhs[k])
		);
	end

	// Third stage, wraps to the word width
	always_ff @(posedge i) begin
		for (int k = 0; k < 3; k++) begin
			c_vec[k] <= prod_lhs[k] - prod_rhs[k];
		end
	end

	assign c_0 = c_vec[0];
	assign c_1 = c_vec[1];
	assign c_2 = c_vec[2];

endmodule

// File: source/fixed_mult.sv
module fixed_mult #(
	parameter int FRAC_BITS = 20
) (
	input  logic            i,
	input  logic            reset,
	input  kin_pkg::coord_t a,
	input  kin_pkg::coord_t b,
	output kin_pkg::coord_t p
);
	import kin_pkg::*;

	localparam int PROD_BITS = 2 * COORD_BITS;

	coord_t                      a_q;
	coord_t                      b_q;
	logic signed [PROD_BITS-1:0] full_prod;
	logic signed [PROD_BITS-1:0] scaled_prod;

	// Full precision product of the registered operands
	assign full_prod = PROD_BITS'(a_q) * PROD_BITS'(b_q);

	// Arithmetic shift floors toward minus infinity
	assign scaled_prod = full_prod >>> FRAC_BITS;

	// Stage one holds the operands, stage two the wrapped result
	always_ff @(posedge i) begin
		if (reset) begin
			a_q <= '0;
			b_q <= '0;
			p   <= '0;
		end else begin
			a_q <= a;
			b_q <= b;
			p   <= scaled_prod[COORD_BITS-1:0];
		end
	end

endmodule

// File: source/frame_capture.sv
module frame_capture (
	input  logic                 i,
	input  logic                 reset,
	input  logic                 frame_valid,
	input  kin_pkg::joint_idx_t  joint,
	input  kin_pkg::joint_kind_e joint_kind,
	input  kin_pkg::coord_t      t_matrix_02,
	input  kin_pkg::coord_t      t_matrix_12,
	input  kin_pkg::coord_t      t_matrix_22,
	input  kin_pkg::coord_t      t_matrix_03,
	input  kin_pkg::coord_t      t_matrix_13,
	input  kin_pkg::coord_t      t_matrix_23,
	input  kin_pkg::coord_t      s_0,
	input  kin_pkg::coord_t      s_1,
	input  kin_pkg::coord_t      s_2,
	input  kin_pkg::joint_idx_t  shadow_sel,
	output logic                 set_ready,
	output kin_pkg::coord_t      shadow_axis_0,
	output kin_pkg::coord_t      shadow_axis_1,
	output kin_pkg::coord_t      shadow_axis_2,
	output kin_pkg::coord_t      shadow_diff_0,
	output kin_pkg::coord_t      shadow_diff_1,
	output kin_pkg::coord_t      shadow_diff_2,
	output kin_pkg::joint_kind_e shadow_kind
);
	import kin_pkg::*;

	localparam int         LAST = NUM_JOINTS - 1;
	localparam joint_idx_t LAST_JOINT = joint_idx_t'(LAST);

	coord_t      in_axis [3];
	coord_t      in_pos [3];
	coord_t      in_s [3];
	logic        last_frame;

	// Joints 0 to 4 wait here, joint 5 goes straight to the shadow bank
	coord_t      work_axis [LAST][3];
	coord_t      work_pos [LAST][3];
	joint_kind_e work_kind [LAST];

	// Stable copy the engine reads while the next set fills in
	coord_t      bank_axis [NUM_JOINTS][3];
	coord_t      bank_diff [NUM_JOINTS][3];
	joint_kind_e bank_kind [NUM_JOINTS];

	// z column and translation column of the incoming transform
	assign in_axis[0] = t_matrix_02;
	assign in_axis[1] = t_matrix_12;
	assign in_axis[2] = t_matrix_22;
	assign in_pos[0]  = t_matrix_03;
	assign in_pos[1]  = t_matrix_13;
	assign in_pos[2]  = t_matrix_23;
	assign in_s[0]    = s_0;
	assign in_s[1]    = s_1;
	assign in_s[2]    = s_2;

	assign last_frame = frame_valid && (joint == LAST_JOINT);

	always_ff @(posedge i) begin
		if (frame_valid && joint != LAST_JOINT) begin
			work_axis[joint] <= in_axis;
			work_pos[joint]  <= in_pos;
			work_kind[joint] <= joint_kind;
		end
	end

	// All six s - p differences in one cycle
	always_ff @(posedge i) begin
		if (last_frame) begin
			for (int j = 0; j < NUM_JOINTS; j++) begin
				for (int c = 0; c < 3; c++) begin
					if (j == LAST) begin
						bank_axis[j][c] <= in_axis[c];
						bank_diff[j][c] <= in_s[c] - in_pos[c];
					end else begin
						bank_axis[j][c] <= work_axis[j][c];
						bank_diff[j][c] <= in_s[c] - work_pos[j][c];
					end
				end
				if (j == LAST) begin
					bank_kind[j] <= joint_kind;
				end else begin
					bank_kind[j] <= work_kind[j];
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (reset) begin
			set_ready <= 1'b0;
		end else begin
			set_ready <= last_frame;
		end
	end

	// Read port for the engine
	assign shadow_axis_0 = bank_axis[shadow_sel][0];
	assign shadow_axis_1 = bank_axis[shadow_sel][1];
	assign shadow_axis_2 = bank_axis[shadow_sel][2];
	assign shadow_diff_0 = bank_diff[shadow_sel][0];
	assign shadow_diff_1 = bank_diff[shadow_sel][1];
	assign shadow_diff_2 = bank_diff[shadow_sel][2];
	assign shadow_kind   = bank_kind[shadow_sel];

	joint_in_range: assert property (@(posedge i) disable iff (reset)
		frame_valid |-> joint <= LAST_JOINT)
		else $error("frame with joint index %0d out of range", joint);

endmodule

// File: source/jacobian_engine.sv
module jacobian_engine #(
	parameter int FRAC_BITS = 20
) (
	input  logic                 i,
	input  logic                 reset,
	input  logic                 set_ready,
	input  kin_pkg::coord_t      shadow_axis_0,
	input  kin_pkg::coord_t      shadow_axis_1,
	input  kin_pkg::coord_t      shadow_axis_2,
	input  kin_pkg::coord_t      shadow_diff_0,
	input  kin_pkg::coord_t      shadow_diff_1,
	input  kin_pkg::coord_t      shadow_diff_2,
	input  kin_pkg::joint_kind_e shadow_kind,
	output kin_pkg::joint_idx_t  shadow_sel,
	output logic                 result_valid,
	output kin_pkg::coord_t      lin_0,
	output kin_pkg::coord_t      lin_1,
	output kin_pkg::coord_t      lin_2,
	output kin_pkg::coord_t      ang_0,
	output kin_pkg::coord_t      ang_1,
	output kin_pkg::coord_t      ang_2
);
	import kin_pkg::*;

	// Matches the cross product latency
	localparam int         PIPE_DEPTH = 3;
	localparam int         OUT_STAGE = PIPE_DEPTH - 1;
	localparam joint_idx_t LAST_JOINT = joint_idx_t'(NUM_JOINTS - 1);

	engine_state_e         state;
	joint_idx_t            issue_count;
	logic                  issue_valid;
	joint_kind_e           issue_kind;
	coord_t                issue_axis [3];
	coord_t                issue_diff [3];
	logic [PIPE_DEPTH-1:0] pipe_valid;
	joint_kind_e           pipe_kind [PIPE_DEPTH];
	coord_t                pipe_axis [PIPE_DEPTH][3];
	coord_t                cross_res [3];
	coord_t                lin_sel [3];
	coord_t                ang_sel [3];

	// Walk through joints 0 to 5, one per cycle
	always_ff @(posedge i) begin
		if (reset) begin
			state       <= ENGINE_IDLE;
			issue_count <= '0;
		end else begin
			case (state)
				ENGINE_IDLE: begin
					if (set_ready) begin
						state       <= ENGINE_ISSUE;
						issue_count <= '0;
					end
				end
				ENGINE_ISSUE: begin
					if (issue_count == LAST_JOINT) begin
						state <= ENGINE_IDLE;
					end else begin
						issue_count <= issue_count + joint_idx_t'(1);
					end
				end
				default: state <= ENGINE_IDLE;
			endcase
		end
	end

	assign shadow_sel = issue_count;

	// Issue register in front of the cross product
	always_ff @(posedge i) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= (state == ENGINE_ISSUE);
		end
	end

	always_ff @(posedge i) begin
		issue_kind    <= shadow_kind;
		issue_axis[0] <= shadow_axis_0;
		issue_axis[1] <= shadow_axis_1;
		issue_axis[2] <= shadow_axis_2;
		issue_diff[0] <= shadow_diff_0;
		issue_diff[1] <= shadow_diff_1;
		issue_diff[2] <= shadow_diff_2;
	end

	cross_product #(
		.FRAC_BITS(FRAC_BITS)
	) cross_inst (
		.i     (i),
		.reset (reset),
		.a_0   (issue_axis[0]),
		.a_1   (issue_axis[1]),
		.a_2   (issue_axis[2]),
		.b_0   (issue_diff[0]),
		.b_1   (issue_diff[1]),
		.b_2   (issue_diff[2]),
		.c_0   (cross_res[0]),
		.c_1   (cross_res[1]),
		.c_2   (cross_res[2])
	);

	// Side pipeline so kind and axis meet their cross product
	always_ff @(posedge i) begin
		if (reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[PIPE_DEPTH-2:0], issue_valid};
		end
	end

	always_ff @(posedge i) begin
		pipe_kind[0] <= issue_kind;
		pipe_axis[0] <= issue_axis;
		for (int s = 1; s < PIPE_DEPTH; s++) begin
			pipe_kind[s] <= pipe_kind[s-1];
			pipe_axis[s] <= pipe_axis[s-1];
		end
	end

	// Revolute gives z x (s - p) and z, prismatic gives z and zero
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			if (pipe_kind[OUT_STAGE] == JOINT_REVOLUTE) begin
				lin_sel[c] = cross_res[c];
				ang_sel[c] = pipe_axis[OUT_STAGE][c];
			end else begin
				lin_sel[c] = pipe_axis[OUT_STAGE][c];
				ang_sel[c] = '0;
			end
		end
	end

	assign result_valid = pipe_valid[OUT_STAGE];
	assign lin_0 = lin_sel[0];
	assign lin_1 = lin_sel[1];
	assign lin_2 = lin_sel[2];
	assign ang_0 = ang_sel[0];
	assign ang_1 = ang_sel[1];
	assign ang_2 = ang_sel[2];

	// Upstream must space sets far enough apart
	no_overlap: assert property (@(posedge i) disable iff (reset)
		set_ready |-> state == ENGINE_IDLE)
		else $error("new joint set ready while the engine is still issuing");

endmodule

// File: source/jacobian_top.sv
module jacobian_top #(
	parameter int FRAC_BITS = 20
) (
	input  logic                 i,
	input  logic                 reset,
	input  logic                 frame_valid,
	input  kin_pkg::joint_idx_t  joint,
	input  kin_pkg::joint_kind_e joint_kind,
	input  kin_pkg::coord_t      t_matrix_02,
	input  kin_pkg::coord_t      t_matrix_12,
	input  kin_pkg::coord_t      t_matrix_22,
	input  kin_pkg::coord_t      t_matrix_03,
	input  kin_pkg::coord_t      t_matrix_13,
	input  kin_pkg::coord_t      t_matrix_23,
	input  kin_pkg::coord_t      s_0,
	input  kin_pkg::coord_t      s_1,
	input  kin_pkg::coord_t      s_2,
	output logic                 col_valid,
	output kin_pkg::joint_idx_t  col_index,
	output kin_pkg::coord_t      jv_0,
	output kin_pkg::coord_t      jv_1,
	output kin_pkg::coord_t      jv_2,
	output kin_pkg::coord_t      jw_0,
	output kin_pkg::coord_t      jw_1,
	output kin_pkg::coord_t      jw_2,
	output logic                 set_done
);
	import kin_pkg::*;

	logic        set_ready;
	joint_idx_t  shadow_sel;
	coord_t      shadow_axis_0;
	coord_t      shadow_axis_1;
	coord_t      shadow_axis_2;
	coord_t      shadow_diff_0;
	coord_t      shadow_diff_1;
	coord_t      shadow_diff_2;
	joint_kind_e shadow_kind;
	logic        result_valid;
	coord_t      lin_0;
	coord_t      lin_1;
	coord_t      lin_2;
	coord_t      ang_0;
	coord_t      ang_1;
	coord_t      ang_2;

	frame_capture frame_capture_inst (
		.i             (i),
		.reset         (reset),
		.frame_valid   (frame_valid),
		.joint         (joint),
		.joint_kind    (joint_kind),
		.t_matrix_02   (t_matrix_02),
		.t_matrix_12   (t_matrix_12),
		.t_matrix_22   (t_matrix_22),
		.t_matrix_03   (t_matrix_03),
		.t_matrix_13   (t_matrix_13),
		.t_matrix_23   (t_matrix_23),
		.s_0           (s_0),
		.s_1           (s_1),
		.s_2           (s_2),
		.shadow_sel    (shadow_sel),
		.set_ready     (set_ready),
		.shadow_axis_0 (shadow_axis_0),
		.shadow_axis_1 (shadow_axis_1),
		.shadow_axis_2 (shadow_axis_2),
		.shadow_diff_0 (shadow_diff_0),
		.shadow_diff_1 (shadow_diff_1),
		.shadow_diff_2 (shadow_diff_2),
		.shadow_kind   (shadow_kind)
	);

	jacobian_engine #(
		.FRAC_BITS(FRAC_BITS)
	) jacobian_engine_inst (
		.i             (i),
		.reset         (reset),
		.set_ready     (set_ready),
		.shadow_axis_0 (shadow_axis_0),
		.shadow_axis_1 (shadow_axis_1),
		.shadow_axis_2 (shadow_axis_2),
		.shadow_diff_0 (shadow_diff_0),
		.shadow_diff_1 (shadow_diff_1),
		.shadow_diff_2 (shadow_diff_2),
		.shadow_kind   (shadow_kind),
		.shadow_sel    (shadow_sel),
		.result_valid  (result_valid),
		.lin_0         (lin_0),
		.lin_1         (lin_1),
		.lin_2         (lin_2),
		.ang_0         (ang_0),
		.ang_1         (ang_1),
		.ang_2         (ang_2)
	);

	column_emitter column_emitter_inst (
		.i            (i),
		.reset        (reset),
		.result_valid (result_valid),
		.lin_0        (lin_0),
		.lin_1        (lin_1),
		.lin_2        (lin_2),
		.ang_0        (ang_0),
		.ang_1        (ang_1),
		.ang_2        (ang_2),
		.col_valid    (col_valid),
		.col_index    (col_index),
		.jv_0         (jv_0),
		.jv_1         (jv_1),
		.jv_2         (jv_2),
		.jw_0         (jw_0),
		.jw_1         (jw_1),
		.jw_2         (jw_2),
		.set_done     (set_done)
	);

endmodule

// File: source/kin_pkg.sv
package kin_pkg;

	// Word width of every coordinate in the datapath
	parameter int COORD_BITS = 27;

	// Signed fixed point, fraction length set per module
	typedef logic signed [COORD_BITS-1:0] coord_t;

	// Joints per arm, one Jacobian column each
	parameter int NUM_JOINTS = 6;

	// Joint or column index
	typedef logic [2:0] joint_idx_t;

	// Revolute joints rotate about z, prismatic ones slide along it
	typedef enum logic {
		JOINT_REVOLUTE  = 1'b0,
		JOINT_PRISMATIC = 1'b1
	} joint_kind_e;

	// Sequencer state of the engine
	typedef enum logic {
		ENGINE_IDLE  = 1'b0,
		ENGINE_ISSUE = 1'b1
	} engine_state_e;

endpackage

// File: test/jacobian_golden.txt
# F joint kind axis_x axis_y axis_z pos_x pos_y pos_z s_x s_y s_z
# C index jv_x jv_y jv_z jw_x jw_y jw_z
# Values are 27-bit hex with 20 fraction bits
# Set 1 is all revolute with s = (2, 1, 3)
F 0 0 0000000 0000000 0100000 0000000 0000000 0000000 0000000 0000000 0000000
F 1 0 0000000 0100000 0000000 0000000 0000000 0100000 0000000 0000000 0000000
F 2 0 0000000 0100000 0000000 0100000 0000000 0100000 0000000 0000000 0000000
F 3 0 0100000 0000000 0000000 0100000 0000000 0200000 0000000 0000000 0000000
F 4 0 0000000 0100000 0000000 0200000 0000000 0200000 0000000 0000000 0000000
F 5 0 0100000 0000000 0000000 0200000 0100000 0280000 0200000 0100000 0300000
C 0 7F00000 0200000 0000000 0000000 0000000 0100000
C 1 0200000 0000000 7E00000 0000000 0100000 0000000
C 2 0200000 0000000 7F00000 0000000 0100000 0000000
C 3 0000000 7F00000 0100000 0100000 0000000 0000000
C 4 0100000 0000000 0000000 0000000 0100000 0000000
C 5 0000000 7F80000 0000000 0100000 0000000 0000000
# Set 2 has prismatic joints 1 and 4 with negative and wrapping values
F 0 0 0000000 0000000 0100000 5800000 0000000 0000000 0000000 0000000 0000000
F 1 1 0000000 7F00000 0000000 0100000 0100000 0100000 0000000 0000000 0000000
F 2 0 0000000 0080000 0000000 0000000 0000000 0000000 0000000 0000000 0000000
F 3 0 0000000 0080000 0000000 3200000 0000000 0200002 0000000 0000000 0000000
F 4 1 7F00000 0000000 0000000 0300000 7C00000 0500000 0000000 0000000 0000000
F 5 0 0100000 0100000 0000000 5000000 5600000 0100001 2800000 7E00000 0100001
C 0 0200000 5000000 0000000 0000000 0000000 0100000
C 1 0000000 7F00000 0000000 0000000 0000000 0000000
C 2 0080000 0000000 6C00000 0000000 0080000 0000000
C 3 7F7FFFF 0000000 0500000 0000000 0080000 0000000
C 4 7F00000 0000000 0000000 0000000 0000000 0000000
C 5 0000000 0000000 5000000 0100000 0100000 0000000

// File: test/jacobian_tb.sv
module jacobian_tb;
	import kin_pkg::*;

	typedef logic [3*COORD_BITS-1:0] vec3_t;

	localparam int         SET_SPACING = 12;
	localparam int         COL_LATENCY = 6;
	localparam joint_idx_t LAST_COL = joint_idx_t'(NUM_JOINTS - 1);

	logic        i;
	logic        reset;
	logic        frame_valid;
	joint_idx_t  joint;
	joint_kind_e joint_kind;
	coord_t      t_matrix_02, t_matrix_12, t_matrix_22;
	coord_t      t_matrix_03, t_matrix_13, t_matrix_23;
	coord_t      s_0, s_1, s_2;
	logic        col_valid;
	joint_idx_t  col_index;
	coord_t      jv_0, jv_1, jv_2;
	coord_t      jw_0, jw_1, jw_2;
	logic        set_done;

	// Golden frames and columns in file order
	joint_idx_t  frame_joint_q [$];
	logic        frame_kind_q [$];
	vec3_t       frame_axis_q [$];
	vec3_t       frame_pos_q [$];
	vec3_t       frame_s_q [$];
	joint_idx_t  col_index_q [$];
	vec3_t       col_jv_q [$];
	vec3_t       col_jw_q [$];

	// Edge that sampled each joint-5 frame
	int          j5_edges [$];

	int          cycle_count = 0;
	int          timeout_limit = 0;
	int          cols_checked = 0;
	int          set_num = 0;
	int          set_base = 0;
	logic [15:0] lfsr_state = 16'd15;
	string       test_name;

	jacobian_top #(
		.FRAC_BITS(20)
	) jacobian_top_inst (
		.i           (i),
		.reset       (reset),
		.frame_valid (frame_valid),
		.joint       (joint),
		.joint_kind  (joint_kind),
		.t_matrix_02 (t_matrix_02),
		.t_matrix_12 (t_matrix_12),
		.t_matrix_22 (t_matrix_22),
		.t_matrix_03 (t_matrix_03),
		.t_matrix_13 (t_matrix_13),
		.t_matrix_23 (t_matrix_23),
		.s_0         (s_0),
		.s_1         (s_1),
		.s_2         (s_2),
		.col_valid   (col_valid),
		.col_index   (col_index),
		.jv_0        (jv_0),
		.jv_1        (jv_1),
		.jv_2        (jv_2),
		.jw_0        (jw_0),
		.jw_1        (jw_1),
		.jw_2        (jw_2),
		.set_done    (set_done)
	);

	initial begin
		i = 1'b0;
		forever #10 i = ~i;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic report_mismatch(input string test, input string field,
			input vec3_t expected, input vec3_t actual);
		$display("** Error: %s, %s expected %0h actual %0h", test, field, expected, actual);
		abort_run();
	endtask

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic idle_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			gap = (gap << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic load_golden();
		int               fd;
		int               rc;
		logic [7:0]       tag;
		logic [8*200-1:0] skip_line;
		joint_idx_t       rd_joint;
		logic             rd_kind;
		coord_t           rd_ax, rd_ay, rd_az;
		coord_t           rd_px, rd_py, rd_pz;
		coord_t           rd_sx, rd_sy, rd_sz;
		fd = $fopen("test/jacobian_golden.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open the golden file test/jacobian_golden.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					rc = $fgets(skip_line, fd);
				end else if (tag == "F") begin
					rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", rd_joint, rd_kind,
						rd_ax, rd_ay, rd_az, rd_px, rd_py, rd_pz, rd_sx, rd_sy, rd_sz);
					if (rc != 11) begin
						report_failure("malformed frame line in the golden file");
					end else begin
						frame_joint_q.push_back(rd_joint);
						frame_kind_q.push_back(rd_kind);
						frame_axis_q.push_back({rd_ax, rd_ay, rd_az});
						frame_pos_q.push_back({rd_px, rd_py, rd_pz});
						frame_s_q.push_back({rd_sx, rd_sy, rd_sz});
					end
				end else if (tag == "C") begin
					rc = $fscanf(fd, "%h %h %h %h %h %h %h", rd_joint,
						rd_ax, rd_ay, rd_az, rd_px, rd_py, rd_pz);
					if (rc != 7) begin
						report_failure("malformed column line in the golden file");
					end else begin
						col_index_q.push_back(rd_joint);
						col_jv_q.push_back({rd_ax, rd_ay, rd_az});
						col_jw_q.push_back({rd_px, rd_py, rd_pz});
					end
				end else begin
					report_failure("unknown line type in the golden file");
				end
			end
			$fclose(fd);
		end
	endtask

	// One-cycle frame strobe starting 2 units after an edge
	task automatic drive_frame(input int n);
		joint       = frame_joint_q[n];
		joint_kind  = joint_kind_e'(frame_kind_q[n]);
		{t_matrix_02, t_matrix_12, t_matrix_22} = frame_axis_q[n];
		{t_matrix_03, t_matrix_13, t_matrix_23} = frame_pos_q[n];
		{s_0, s_1, s_2} = frame_s_q[n];
		frame_valid = 1'b1;
		if (frame_joint_q[n] == LAST_COL) begin
			j5_edges.push_back(cycle_count + 1);
		end
		@(posedge i);
		#2;
		frame_valid = 1'b0;
	endtask

	task automatic check_column();
		joint_idx_t exp_idx;
		int         exp_edge;
		if (cols_checked >= col_index_q.size()) begin
			report_failure("a column arrived after the last expected column");
		end else begin
			exp_idx = col_index_q[cols_checked];
			if (exp_idx == '0 && set_num >= j5_edges.size()) begin
				report_failure("column 0 arrived before its joint set was sent");
			end else begin
				if (exp_idx == '0) begin
					set_base = j5_edges[set_num];
					set_num++;
				end
				test_name = $sformatf("set %0d column %0d", set_num, exp_idx);
				exp_edge = set_base + COL_LATENCY + int'(exp_idx);
				assert (col_index == exp_idx)
					else report_mismatch(test_name, "col_index", vec3_t'(exp_idx),
						vec3_t'(col_index));
				assert (cycle_count == exp_edge)
					else report_mismatch(test_name, "arrival edge", vec3_t'(exp_edge),
						vec3_t'(cycle_count));
				assert ({jv_0, jv_1, jv_2} == col_jv_q[cols_checked])
					else report_mismatch(test_name, "jv", col_jv_q[cols_checked],
						{jv_0, jv_1, jv_2});
				assert ({jw_0, jw_1, jw_2} == col_jw_q[cols_checked])
					else report_mismatch(test_name, "jw", col_jw_q[cols_checked],
						{jw_0, jw_1, jw_2});
				assert (set_done == (exp_idx == LAST_COL))
					else report_mismatch(test_name, "set_done", vec3_t'(exp_idx == LAST_COL),
						vec3_t'(set_done));
				cols_checked++;
			end
		end
	endtask

	// Edge counter and timeout
	always @(posedge i) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			report_failure($sformatf("timeout after %0d cycles, only %0d of %0d columns arrived",
				cycle_count, cols_checked, col_index_q.size()));
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge i) begin
		if (!reset) begin
			if (col_valid) begin
				check_column();
			end else begin
				test_name = $sformatf("idle cycle at edge %0d", cycle_count);
				assert (!set_done)
					else report_mismatch(test_name, "set_done", '0, vec3_t'(set_done));
			end
		end
	end

	initial begin
		int gap;
		reset       = 1'b1;
		frame_valid = 1'b0;
		joint       = '0;
		joint_kind  = JOINT_REVOLUTE;
		t_matrix_02 = '0;
		t_matrix_12 = '0;
		t_matrix_22 = '0;
		t_matrix_03 = '0;
		t_matrix_13 = '0;
		t_matrix_23 = '0;
		s_0         = '0;
		s_1         = '0;
		s_2         = '0;
		load_golden();
		timeout_limit = (frame_joint_q.size() + col_index_q.size()) * 20 + 50;
		repeat (2) @(posedge i);
		#2;
		reset = 1'b0;
		// Next set starts at once and only its joint 5 waits for the spacing
		for (int n = 0; n < frame_joint_q.size(); n++) begin
			if (frame_joint_q[n] == LAST_COL && j5_edges.size() > 0) begin
				while (cycle_count + 1 - j5_edges[$] < SET_SPACING) begin
					@(posedge i);
					#2;
				end
			end
			drive_frame(n);
			idle_gap(gap);
			repeat (gap) begin
				@(posedge i);
				#2;
			end
		end
		wait (cols_checked == col_index_q.size());
		repeat (4) @(negedge i);
		#5;
		$display("Result: PASSED");
		$finish;
	end

endmodule
